// ==== filelist.f ====
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_fetch.sv
hdl/rv_stage_reg.sv
hdl/rv_core.sv
verif/rv_core_tb.sv

// ==== hdl/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu (
    input  rv_core_pkg::alu_op_e  op,
    input  rv_core_pkg::word_t    a,
    input  rv_core_pkg::word_t    b,
    output rv_core_pkg::word_t    result,
    input  rv_core_pkg::br_kind_e br_kind,
    output logic                  br_taken
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = word_t'(a < b);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    // ----------------------------------------
    // branch condition
    // ----------------------------------------
    always_comb begin
        case (br_kind)
            BR_EQ:   br_taken = (a == b);
            BR_NE:   br_taken = (a != b);
            BR_LT:   br_taken = ($signed(a) < $signed(b));
            BR_GE:   br_taken = ($signed(a) >= $signed(b));
            BR_LTU:  br_taken = (a < b);
            BR_GEU:  br_taken = (a >= b);
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
    input  logic                 clk,
    input  logic                 rst,
    output rv_core_pkg::word_t   imem_addr,
    input  rv_core_pkg::word_t   imem_data,
    output logic                 retire_valid,
    output rv_core_pkg::retire_t retire,
    output logic                 halt
);
    import rv_core_pkg::*;

    word_t fetch_pc;
    fd_t   fd_d;
    fd_t   fd_q;
    logic  fd_valid;
    word_t rs1_data;
    word_t rs2_data;
    de_t   de_d;
    de_t   de_q;
    logic  de_valid;
    xw_t   ex_result;
    xw_t   mem_q;
    logic  mem_valid;
    xw_t   wb_q;
    logic  wb_valid;
    logic  redirect;
    word_t redirect_pc;
    logic  halt_q;
    logic  wb_ebreak;

    // ----------------------------------------
    // fetch
    // ----------------------------------------
    rv_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (fetch_pc)
    );

    assign imem_addr = fetch_pc;
    assign fd_d      = '{pc: fetch_pc, instr: imem_data};

    rv_stage_reg #(.payload_t(fd_t)) u_fd_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .valid_in  (1'b1),
        .data_in   (fd_d),
        .valid_out (fd_valid),
        .data_out  (fd_q)
    );

    // ----------------------------------------
    // decode
    // ----------------------------------------
    rv_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (fd_q.instr[19:15]),
        .raddr2 (fd_q.instr[24:20]),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (wb_valid && wb_q.we),
        .waddr  (wb_q.rd),
        .wdata  (wb_q.result)
    );

    rv_decoder u_decoder (
        .fetch    (fd_q),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .decoded  (de_d)
    );

    rv_stage_reg #(.payload_t(de_t)) u_de_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .valid_in  (fd_valid),
        .data_in   (de_d),
        .valid_out (de_valid),
        .data_out  (de_q)
    );

    // ----------------------------------------
    // execute, memory, writeback
    // ----------------------------------------
    rv_execute u_execute (
        .dec         (de_q),
        .dec_valid   (de_valid),
        .mem_fwd     (mem_q),
        .mem_valid   (mem_valid),
        .wb_fwd      (wb_q),
        .wb_valid    (wb_valid),
        .result      (ex_result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    rv_stage_reg #(.payload_t(xw_t)) u_mem_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (1'b0),
        .valid_in  (de_valid),
        .data_in   (ex_result),
        .valid_out (mem_valid),
        .data_out  (mem_q)
    );

    // memory stage only delays by one cycle
    rv_stage_reg #(.payload_t(xw_t)) u_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .flush     (1'b0),
        .valid_in  (mem_valid),
        .data_in   (mem_q),
        .valid_out (wb_valid),
        .data_out  (wb_q)
    );

    assign retire_valid = wb_valid;
    assign retire       = '{pc: wb_q.pc, rd: wb_q.rd, result: wb_q.result, we: wb_q.we};

    // halt shows in the ebreak's own retire cycle and then sticks
    assign wb_ebreak = wb_valid && wb_q.ebreak;
    assign halt      = halt_q || wb_ebreak;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_q <= 1'b0;
        end else if (wb_ebreak) begin
            halt_q <= 1'b1;
        end
    end

    // ebreak never writes a register
    a_ebreak_no_write: assert property (@(posedge clk) disable iff (rst)
        wb_ebreak |-> !wb_q.we);

endmodule

// ==== hdl/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath and address width
`define RV_XLEN 32

// architectural register count
`define RV_REG_COUNT 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== hdl/rv_core_pkg.sv ====
`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_addr_t;

    // major opcodes seen by the decoder
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_kind_e;

    // writeback value source
    typedef enum logic [1:0] {
        RES_ALU,
        RES_PC4,
        RES_IMM
    } res_sel_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        word_t     pc;
        word_t     imm;
        word_t     rs1_val;
        word_t     rs2_val;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        br_kind_e  br_kind;
        res_sel_e  res_sel;
        logic      reg_write;
        logic      src_b_reg;
        logic      src_a_pc;
        logic      src_a_zero;
        logic      jal;
        logic      jalr;
        logic      ebreak;
    } de_t;

    // execute/memory and memory/writeback share this layout
    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t rd;
        logic      we;
        logic      ebreak;
    } xw_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     result;
        logic      we;
    } retire_t;

endpackage

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/10ps

module rv_decoder (
    input  rv_core_pkg::fd_t   fetch,
    input  rv_core_pkg::word_t rs1_data,
    input  rv_core_pkg::word_t rs2_data,
    output rv_core_pkg::de_t   decoded
);
    import rv_core_pkg::*;

    word_t   instr;
    opcode_e opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;

    // funct3 to ALU op, alt picks sub / sra
    function automatic alu_op_e alu_from_funct(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_kind_e br_from_funct(logic [2:0] funct3);
        case (funct3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    assign instr  = fetch.instr;
    assign opcode = opcode_e'(instr[6:0]);

    // ----------------------------------------
    // immediate formats
    // ----------------------------------------
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded         = '0;
        decoded.pc      = fetch.pc;
        decoded.rs1     = instr[19:15];
        decoded.rs2     = instr[24:20];
        decoded.rd      = instr[11:7];
        decoded.rs1_val = rs1_data;
        decoded.rs2_val = rs2_data;
        decoded.alu_op  = ALU_ADD;
        decoded.br_kind = BR_NONE;
        decoded.res_sel = RES_ALU;

        case (opcode)
            OP_LUI: begin
                decoded.imm        = imm_u;
                decoded.reg_write  = 1'b1;
                decoded.src_a_zero = 1'b1;
                decoded.alu_op     = ALU_PASS_B;
            end
            OP_AUIPC: begin
                decoded.imm       = imm_u;
                decoded.reg_write = 1'b1;
                decoded.src_a_pc  = 1'b1;
            end
            OP_JAL: begin
                decoded.imm       = imm_j;
                decoded.reg_write = 1'b1;
                decoded.jal       = 1'b1;
                decoded.res_sel   = RES_PC4;
            end
            OP_JALR: begin
                decoded.imm       = imm_i;
                decoded.reg_write = 1'b1;
                decoded.jalr      = 1'b1;
                decoded.res_sel   = RES_PC4;
            end
            OP_BRANCH: begin
                // compare runs on rs1 vs rs2
                decoded.imm       = imm_b;
                decoded.src_b_reg = 1'b1;
                decoded.br_kind   = br_from_funct(instr[14:12]);
            end
            OP_IMM: begin
                decoded.imm       = imm_i;
                decoded.reg_write = 1'b1;
                decoded.alu_op    = alu_from_funct(instr[14:12],
                                                   (instr[14:12] == 3'b101) && instr[30]);
            end
            OP_REG: begin
                decoded.reg_write = 1'b1;
                decoded.src_b_reg = 1'b1;
                decoded.alu_op    = alu_from_funct(instr[14:12], instr[30]);
            end
            OP_STORE: begin
                // no data memory, slot retires empty
                decoded.imm = imm_s;
            end
            OP_LOAD, OP_FENCE: begin
                decoded.imm = imm_i;
            end
            OP_SYSTEM: begin
                decoded.ebreak = (instr == 32'h0010_0073);
            end
            default: begin
            end
        endcase

        // x0 is never written
        if (decoded.rd == '0) begin
            decoded.reg_write = 1'b0;
        end
    end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute (
    input  rv_core_pkg::de_t   dec,
    input  logic               dec_valid,
    input  rv_core_pkg::xw_t   mem_fwd,
    input  logic               mem_valid,
    input  rv_core_pkg::xw_t   wb_fwd,
    input  logic               wb_valid,
    output rv_core_pkg::xw_t   result,
    output logic               redirect,
    output rv_core_pkg::word_t redirect_pc
);
    import rv_core_pkg::*;

    word_t src1;
    word_t src2;
    word_t op_a;
    word_t op_b;
    word_t alu_y;
    word_t jalr_sum;
    logic  br_taken;

    // the younger memory stage has priority
    function automatic word_t forward(reg_addr_t idx, word_t read_val);
        if (mem_valid && mem_fwd.we && mem_fwd.rd == idx && idx != '0) begin
            return mem_fwd.result;
        end
        if (wb_valid && wb_fwd.we && wb_fwd.rd == idx && idx != '0) begin
            return wb_fwd.result;
        end
        return read_val;
    endfunction

    always_comb begin
        src1 = forward(dec.rs1, dec.rs1_val);
        src2 = forward(dec.rs2, dec.rs2_val);
    end

    // ----------------------------------------
    // operand select
    // ----------------------------------------
    assign op_a = dec.src_a_zero ? '0 :
                  dec.src_a_pc   ? dec.pc : src1;
    assign op_b = dec.src_b_reg  ? src2 : dec.imm;

    rv_alu u_alu (
        .op       (dec.alu_op),
        .a        (op_a),
        .b        (op_b),
        .result   (alu_y),
        .br_kind  (dec.br_kind),
        .br_taken (br_taken)
    );

    always_comb begin
        result.pc     = dec.pc;
        result.rd     = dec.rd;
        result.we     = dec.reg_write;
        result.ebreak = dec.ebreak;
        case (dec.res_sel)
            RES_PC4: result.result = dec.pc + word_t'(4);
            RES_IMM: result.result = dec.imm;
            default: result.result = alu_y;
        endcase
    end

    // jump targets
    assign jalr_sum    = src1 + dec.imm;
    assign redirect    = dec_valid && (dec.jal || dec.jalr || br_taken);
    assign redirect_pc = dec.jalr ? {jalr_sum[$bits(word_t)-1:1], 1'b0}
                                  : dec.pc + dec.imm;

endmodule

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect,
    input  rv_core_pkg::word_t redirect_pc,
    output rv_core_pkg::word_t pc
);
    import rv_core_pkg::*;

    // no prediction, fall through until execute redirects
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_core_pkg::reg_addr_t raddr1,
    input  rv_core_pkg::reg_addr_t raddr2,
    output rv_core_pkg::word_t     rdata1,
    output rv_core_pkg::word_t     rdata2,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t waddr,
    input  rv_core_pkg::word_t     wdata
);
    import rv_core_pkg::*;

    word_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // writeback in the same cycle wins over the stored value
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

    // the decoder drops writes to x0 before they get here
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        we |-> (waddr != '0));

endmodule

// ==== hdl/rv_stage_reg.sv ====
`timescale 1ns/10ps

module rv_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    // a bubble is just a cleared valid
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= data_in;
    end

    // a valid slot never carries unknown bits
    a_valid_data_known: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> !$isunknown(data_out));

endmodule

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam string TESTS_FILE   = "verif/rv_core_tests.txt";
    localparam int    IMEM_WORDS   = 256;
    localparam int    RESET_CYCLES = 16;

    logic    clk;
    logic    rst;
    word_t   imem_addr;
    word_t   imem_data;
    logic    retire_valid;
    retire_t retire;
    logic    halt;

    word_t   imem [IMEM_WORDS];
    logic    imem_loaded [IMEM_WORDS];
    retire_t exp_rec [$];
    string   exp_group [$];

    int      rec_idx;
    int      group_start;
    int      mismatches;
    int      groups_passed;
    int      groups_failed;
    int      other_errors;
    int      cycle_count;
    int      cycle_limit;
    logic    load_ok;
    logic    halt_seen;

    rv_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halt         (halt)
    );

    // instruction port answers in the same cycle, empty slots read as nop
    assign imem_data = (imem_addr[31:10] == '0 && imem_loaded[imem_addr[9:2]] === 1'b1) ?
                       imem[imem_addr[9:2]] : `RV_NOP;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ----------------------------------------
    // test file parsing
    // ----------------------------------------
    task automatic load_tests();
        int          fd;
        int          n;
        int          addr;
        word_t       instr;
        string       line;
        string       grp;
        logic [31:0] f_pc;
        logic [31:0] f_rd;
        logic [31:0] f_we;
        logic [31:0] f_val;
        retire_t     rec;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem_loaded[i] = 1'b0;
        end
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test file %s", TESTS_FILE);
            load_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] == "P") begin
                n = $sscanf(line, "P %h %h", addr, instr);
                if (n != 2 || addr < 0 || addr >= IMEM_WORDS) begin
                    $display("unreadable program line: %s", line);
                    load_ok = 1'b0;
                end else begin
                    imem[addr]        = instr;
                    imem_loaded[addr] = 1'b1;
                end
            end else if (n > 0 && line.len() > 0 && line[0] == "E") begin
                n = $sscanf(line, "E %h %h %h %h %s", f_pc, f_rd, f_we, f_val, grp);
                if (n != 5) begin
                    $display("unreadable expected line: %s", line);
                    load_ok = 1'b0;
                end else begin
                    rec.pc     = f_pc;
                    rec.rd     = f_rd[4:0];
                    rec.result = f_val;
                    rec.we     = f_we[0];
                    exp_rec.push_back(rec);
                    exp_group.push_back(grp);
                end
            end
        end
        $fclose(fd);
        if (exp_rec.size() == 0) begin
            $display("the test file holds no expected retire records");
            load_ok = 1'b0;
        end
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_retire(retire_t expected, retire_t actual);
        if (actual.pc !== expected.pc) begin
            $display("FAIL retire.pc expected %h actual %h", expected.pc, actual.pc);
            mismatches++;
        end
        if (actual.we !== expected.we) begin
            $display("FAIL retire.we expected %h actual %h", expected.we, actual.we);
            mismatches++;
        end else if (expected.we) begin
            // rd and value only mean something on a write
            if (actual.rd !== expected.rd) begin
                $display("FAIL retire.rd expected %h actual %h", expected.rd, actual.rd);
                mismatches++;
            end
            if (actual.result !== expected.result) begin
                $display("FAIL retire.result expected %h actual %h",
                         expected.result, actual.result);
                mismatches++;
            end
        end
    endtask

    task automatic check_halt(logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL halt expected %h actual %h", expected, actual);
            mismatches++;
        end
    endtask

    task automatic close_group(string name, int records);
        if (mismatches == 0) begin
            $display("test %s: ok, %0d retires checked", name, records);
            groups_passed++;
        end else begin
            $display("test %s: %0d mismatches in %0d retires", name, mismatches, records);
            groups_failed++;
        end
        mismatches = 0;
    endtask

    task automatic take_retire();
        logic last_rec;
        logic last_in_group;
        if (rec_idx >= exp_rec.size()) begin
            $display("an extra instruction retired at pc %h after the expected trace",
                     retire.pc);
            other_errors++;
            return;
        end
        last_rec = (rec_idx == exp_rec.size() - 1);
        check_retire(exp_rec[rec_idx], retire);
        // only the final ebreak may raise halt
        check_halt(last_rec, halt);
        last_in_group = last_rec || (exp_group[rec_idx + 1] != exp_group[rec_idx]);
        if (last_in_group) begin
            close_group(exp_group[rec_idx], rec_idx - group_start + 1);
            group_start = rec_idx + 1;
        end
        rec_idx++;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        rst           = 1'b1;
        rec_idx       = 0;
        group_start   = 0;
        mismatches    = 0;
        groups_passed = 0;
        groups_failed = 0;
        other_errors  = 0;
        load_ok       = 1'b1;
        halt_seen     = 1'b0;
        load_tests();
        if (!load_ok) begin
            other_errors++;
        end
        cycle_limit = 4 * exp_rec.size() + 64;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // sample on the falling edge, away from register updates
        while (load_ok && !halt_seen) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                take_retire();
            end
            halt_seen = (halt === 1'b1);
        end
        if (halt_seen && rec_idx != exp_rec.size()) begin
            $display("halt came with only %0d of %0d expected retires seen",
                     rec_idx, exp_rec.size());
            other_errors++;
        end
        $display("tests passed %0d failed %0d, other errors %0d",
                 groups_passed, groups_failed, other_errors);
        if (groups_failed == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // cycle budget scales with the expected trace
    initial begin
        cycle_count = 0;
        wait (rst === 1'b0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: retirement stalled, %0d of %0d retires seen in %0d cycles",
                 rec_idx, exp_rec.size(), cycle_count);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== verif/rv_core_tests.txt ====
# P <word address> <instruction word>
# E <pc> <rd> <we> <value> <test group>, expected retires in program order
P 00 800000b7
P 01 00500113
P 02 4020d1b3
P 03 0020a233
P 04 0020b2b3
P 05 40110333
P 06 002303b3
P 07 0013c433
P 08 002464b3
P 09 0074f533
P 0a 002115b3
P 0b 0020d633
P 0c 4040d693
P 0d 0010a713
P 0e 0010b793
P 0f fff14813
P 10 03016893
P 11 0ff87913
P 12 00811993
P 13 01f0da13
P 14 00001a97
E 00000000 01 1 80000000 alu
E 00000004 02 1 00000005 alu
E 00000008 03 1 fc000000 alu
E 0000000c 04 1 00000001 alu
E 00000010 05 1 00000000 alu
E 00000014 06 1 80000005 alu
E 00000018 07 1 8000000a alu
E 0000001c 08 1 0000000a alu
E 00000020 09 1 0000000f alu
E 00000024 0a 1 0000000a alu
E 00000028 0b 1 000000a0 alu
E 0000002c 0c 1 04000000 alu
E 00000030 0d 1 f8000000 alu
E 00000034 0e 1 00000001 alu
E 00000038 0f 1 00000000 alu
E 0000003c 10 1 fffffffa alu
E 00000040 11 1 00000035 alu
E 00000044 12 1 000000fa alu
E 00000048 13 1 00000500 alu
E 0000004c 14 1 00000001 alu
E 00000050 15 1 00001050 alu
# dependent chain at distances one, two and three
P 15 00700b13
P 16 001b0b93
P 17 017b0c33
P 18 018b0cb3
P 19 417c8d33
E 00000054 16 1 00000007 forwarding
E 00000058 17 1 00000008 forwarding
E 0000005c 18 1 0000000f forwarding
E 00000060 19 1 00000016 forwarding
E 00000064 1a 1 0000000e forwarding
# each branch not taken then taken by +12, word 1c is a shadow addi x31
P 1a 01610663
P 1b 00210663
P 1c 00100f93
P 1e 00211663
P 1f 01611663
P 22 00114663
P 23 0020c663
P 26 0020d663
P 27 00115663
P 2a 0020e663
P 2b 00116663
P 2e 00117663
P 2f 0020f663
E 00000068 00 0 00000000 branches
E 0000006c 00 0 00000000 branches
E 00000078 00 0 00000000 branches
E 0000007c 00 0 00000000 branches
E 00000088 00 0 00000000 branches
E 0000008c 00 0 00000000 branches
E 00000098 00 0 00000000 branches
E 0000009c 00 0 00000000 branches
E 000000a8 00 0 00000000 branches
E 000000ac 00 0 00000000 branches
E 000000b8 00 0 00000000 branches
E 000000bc 00 0 00000000 branches
# jal x5, addi x7 then jalr x6 to an odd target, jal x0
P 32 00c002ef
P 35 0e500393
P 36 00438367
P 3a 0080006f
E 000000c8 05 1 000000cc jumps
E 000000d4 07 1 000000e5 jumps
E 000000d8 06 1 000000dc jumps
E 000000e8 00 0 00000000 jumps
# store word as a no-op, then ebreak
P 3c 00202023
P 3d 00100073
E 000000f0 00 0 00000000 halt
E 000000f4 00 0 00000000 halt
